// File: hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and character widths.
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W  = 16;
  localparam int ADDR_W  = 11;
  localparam int NB_BITS = 8;

  // First register of the UART window on the CPU bus.
  localparam logic [ADDR_W-1:0] BASE_ADDR = '0;

  ////////////////////////////////////////////////////////////////////////////
  // Baud timing.
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLKS_PER_TICK = 2;   // Clock cycles per oversampling tick.
  localparam int OVERSAMPLE    = 16;  // Ticks per serial bit.

  localparam int TICK_CNT_W = $clog2(CLKS_PER_TICK);
  localparam int OS_CNT_W   = $clog2(OVERSAMPLE);
  localparam int BIT_CNT_W  = $clog2(NB_BITS);

  // Tick on which the receiver checks the middle of the start bit.
  localparam int START_MID = OVERSAMPLE / 2 - 1;

  ////////////////////////////////////////////////////////////////////////////
  // Register map and state encodings.
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [ADDR_W-1:0] {
    REG_TX_DATA  = 11'd0,
    REG_TX_DONE  = 11'd1,
    REG_TX_START = 11'd2,
    REG_RX_DATA  = 11'd3,
    REG_RX_DONE  = 11'd4
  } reg_addr_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  // One CPU bus cycle.
  typedef struct packed {
    logic              cs;     // Chip select.
    logic              we;     // 1 writes, 0 reads.
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

endpackage

`default_nettype wire

// File: hdl/uart_baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
  input  logic i_clk,
  input  logic i_rst,
  output logic o_tick
);

  localparam logic [uart_pkg::TICK_CNT_W-1:0] LAST_CNT =
    uart_pkg::TICK_CNT_W'(uart_pkg::CLKS_PER_TICK - 1);

  logic [uart_pkg::TICK_CNT_W-1:0] cnt;

  // Free-running divider. The tick is high for one clock at each wrap.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt    <= '0;
      o_tick <= 1'b0;
    end else if (cnt == LAST_CNT) begin
      cnt    <= '0;
      o_tick <= 1'b1;
    end else begin
      cnt    <= cnt + 1'b1;
      o_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_tick,
  input  logic                        i_rx,
  output logic [uart_pkg::NB_BITS-1:0] o_data,
  output logic                        o_done
);

  localparam logic [uart_pkg::OS_CNT_W-1:0] OS_LAST =
    uart_pkg::OS_CNT_W'(uart_pkg::OVERSAMPLE - 1);
  localparam logic [uart_pkg::OS_CNT_W-1:0] OS_MID =
    uart_pkg::OS_CNT_W'(uart_pkg::START_MID);
  localparam logic [uart_pkg::BIT_CNT_W-1:0] BIT_LAST =
    uart_pkg::BIT_CNT_W'(uart_pkg::NB_BITS - 1);

  uart_pkg::rx_state_e state;

  logic                          rx_meta;
  logic                          rx_sync;
  logic [uart_pkg::OS_CNT_W-1:0]  os_cnt;
  logic [uart_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [uart_pkg::NB_BITS-1:0]   shreg;
  logic                          load_data;

  // The line idles high, so the synchronizer resets to 1.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame FSM.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= uart_pkg::RX_IDLE;
      os_cnt  <= '0;
      bit_cnt <= '0;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        uart_pkg::RX_IDLE: begin
          if (!rx_sync) begin
            state  <= uart_pkg::RX_START;
            os_cnt <= '0;
          end
        end
        uart_pkg::RX_START: begin
          if (i_tick) begin
            if (os_cnt == OS_MID) begin
              // A glitch that is gone by mid-bit is not a start bit.
              state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
              os_cnt  <= '0;
              bit_cnt <= '0;
            end else begin
              os_cnt <= os_cnt + 1'b1;
            end
          end
        end
        uart_pkg::RX_DATA: begin
          if (i_tick) begin
            os_cnt <= os_cnt + 1'b1;   // Wraps to 0 after the last tick.
            if (os_cnt == OS_LAST) begin
              if (bit_cnt == BIT_LAST) state <= uart_pkg::RX_STOP;
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default: begin
          if (i_tick) begin
            os_cnt <= os_cnt + 1'b1;
            if (os_cnt == OS_LAST) begin
              state  <= uart_pkg::RX_IDLE;
              o_done <= rx_sync;       // Low stop bit drops the frame.
            end
          end
        end
      endcase
    end
  end

  assign load_data = (state == uart_pkg::RX_STOP) && i_tick && (os_cnt == OS_LAST) && rx_sync;

  // Data bits arrive LSB first.
  always_ff @(posedge i_clk) begin
    if ((state == uart_pkg::RX_DATA) && i_tick && (os_cnt == OS_LAST)) begin
      shreg <= {rx_sync, shreg[uart_pkg::NB_BITS-1:1]};
    end
    if (load_data) begin
      o_data <= shreg;
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_tick,
  input  logic                        i_start,
  input  logic [uart_pkg::NB_BITS-1:0] i_data,
  output logic                        o_tx,
  output logic                        o_done
);

  localparam logic [uart_pkg::OS_CNT_W-1:0] OS_LAST =
    uart_pkg::OS_CNT_W'(uart_pkg::OVERSAMPLE - 1);
  localparam logic [uart_pkg::BIT_CNT_W-1:0] BIT_LAST =
    uart_pkg::BIT_CNT_W'(uart_pkg::NB_BITS - 1);

  uart_pkg::tx_state_e state;

  logic [uart_pkg::OS_CNT_W-1:0]  os_cnt;
  logic [uart_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [uart_pkg::NB_BITS-1:0]   shreg;
  logic                          bit_end;

  assign bit_end = i_tick && (os_cnt == OS_LAST);

  ////////////////////////////////////////////////////////////////////////////
  // Frame FSM.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= uart_pkg::TX_IDLE;
      os_cnt  <= '0;
      bit_cnt <= '0;
      o_tx    <= 1'b1;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (state != uart_pkg::TX_IDLE && i_tick) os_cnt <= os_cnt + 1'b1;
      case (state)
        uart_pkg::TX_IDLE: begin
          // Start is still high during the done pulse; it is cleared a cycle later.
          if (i_tick && i_start && !o_done) begin
            state  <= uart_pkg::TX_START;
            os_cnt <= '0;
            o_tx   <= 1'b0;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_end) begin
            state   <= uart_pkg::TX_DATA;
            bit_cnt <= '0;
            o_tx    <= shreg[0];
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_LAST) begin
              state <= uart_pkg::TX_STOP;
              o_tx  <= 1'b1;
            end else begin
              o_tx <= shreg[0];
            end
          end
        end
        default: begin
          if (bit_end) begin
            state  <= uart_pkg::TX_IDLE;
            o_done <= 1'b1;
          end
        end
      endcase
    end
  end

  // The byte is latched at frame start, so later writes do not disturb it.
  always_ff @(posedge i_clk) begin
    if (state == uart_pkg::TX_IDLE) begin
      shreg <= i_data;
    end else if (bit_end && state != uart_pkg::TX_STOP) begin
      shreg <= {1'b1, shreg[uart_pkg::NB_BITS-1:1]};
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  uart_pkg::bus_req_t          i_bus,
  output logic [uart_pkg::DATA_W-1:0]  o_rdata,
  input  logic [uart_pkg::NB_BITS-1:0] i_rx_data,
  input  logic                        i_rx_done,
  input  logic                        i_tx_done,
  output logic [uart_pkg::NB_BITS-1:0] o_tx_data,
  output logic                        o_tx_start
);

  logic [uart_pkg::DATA_W-1:0] tx_data_q;
  logic [uart_pkg::DATA_W-1:0] tx_done_q;
  logic [uart_pkg::DATA_W-1:0] tx_start_q;
  logic [uart_pkg::DATA_W-1:0] rx_data_q;
  logic [uart_pkg::DATA_W-1:0] rx_done_q;

  logic [uart_pkg::ADDR_W-1:0] addr_off;
  logic                       bus_wr;
  logic                       bus_rd;

  assign addr_off = i_bus.addr - uart_pkg::BASE_ADDR;
  assign bus_wr   = i_bus.cs && i_bus.we;
  assign bus_rd   = i_bus.cs && !i_bus.we;

  ////////////////////////////////////////////////////////////////////////////
  // Bus writes, then hardware updates.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      tx_data_q  <= '0;
      tx_done_q  <= '0;
      tx_start_q <= '0;
      rx_data_q  <= '0;
      rx_done_q  <= '0;
    end else begin
      if (bus_wr) begin
        case (addr_off)
          uart_pkg::REG_TX_DATA:  tx_data_q  <= i_bus.wdata;
          uart_pkg::REG_TX_DONE:  tx_done_q  <= i_bus.wdata;
          uart_pkg::REG_TX_START: tx_start_q <= i_bus.wdata;
          uart_pkg::REG_RX_DATA:  rx_data_q  <= i_bus.wdata;
          uart_pkg::REG_RX_DONE:  rx_done_q  <= i_bus.wdata;
          default: ;  // Outside the window.
        endcase
      end
      // Placed after the bus writes so that the UART side wins a collision.
      if (i_rx_done) begin
        rx_data_q <= {{(uart_pkg::DATA_W-uart_pkg::NB_BITS){1'b0}}, i_rx_data};
        rx_done_q <= uart_pkg::DATA_W'(1);
      end
      if (i_tx_done) begin
        tx_done_q  <= uart_pkg::DATA_W'(1);
        tx_start_q <= '0;   // Lets the CPU side run again.
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered reads.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rdata <= '0;
    end else if (bus_rd) begin
      case (addr_off)
        uart_pkg::REG_TX_DATA:  o_rdata <= tx_data_q;
        uart_pkg::REG_TX_DONE:  o_rdata <= tx_done_q;
        uart_pkg::REG_TX_START: o_rdata <= tx_start_q;
        uart_pkg::REG_RX_DATA:  o_rdata <= rx_data_q;
        uart_pkg::REG_RX_DONE:  o_rdata <= rx_done_q;
        default: ;  // Keeps the last value read.
      endcase
    end
  end

  assign o_tx_data  = tx_data_q[uart_pkg::NB_BITS-1:0];
  assign o_tx_start = tx_start_q[0];

endmodule

`default_nettype wire

// File: hdl/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  uart_pkg::bus_req_t         i_bus,
  output logic [uart_pkg::DATA_W-1:0] o_rdata,
  input  logic                       i_rx,
  output logic                       o_tx,
  output logic                       o_cpu_enable
);

  logic                        tick;
  logic [uart_pkg::NB_BITS-1:0] rx_data;
  logic                        rx_done;
  logic [uart_pkg::NB_BITS-1:0] tx_data;
  logic                        tx_start;
  logic                        tx_done;

  // High for the whole transmission, so the CPU can stall on it.
  assign o_cpu_enable = tx_start;

  uart_regs u_regs (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_bus      (i_bus),
    .o_rdata    (o_rdata),
    .i_rx_data  (rx_data),
    .i_rx_done  (rx_done),
    .i_tx_done  (tx_done),
    .o_tx_data  (tx_data),
    .o_tx_start (tx_start)
  );

  uart_baud_gen u_baud_gen (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .o_tick (tick)
  );

  uart_rx u_rx (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_tick (tick),
    .i_rx   (i_rx),
    .o_data (rx_data),
    .o_done (rx_done)
  );

  uart_tx u_tx (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_tick  (tick),
    .i_start (tx_start),
    .i_data  (tx_data),
    .o_tx    (o_tx),
    .o_done  (tx_done)
  );

endmodule

`default_nettype wire

// File: test/uart_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_checker (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  uart_pkg::bus_req_t          i_bus,
  input  logic [uart_pkg::DATA_W-1:0] i_rdata,
  input  logic                        i_tx,
  input  logic                        i_cpu_enable,
  input  logic                        i_tx_done
);

  int fail_cnt;

  initial fail_cnt = 0;

  // The line only leaves idle while a transmit request is pending.
  a_tx_idle_high : assert property (@(posedge i_clk) disable iff (i_rst)
    !i_cpu_enable |-> i_tx)
    else begin
      fail_cnt++;
      $error("o_tx is low with no frame in progress");
    end

  a_enable_fall : assert property (@(posedge i_clk) disable iff (i_rst)
    $fell(i_cpu_enable) |-> $past(i_tx_done))
    else begin
      fail_cnt++;
      $error("o_cpu_enable fell without a transmit done pulse");
    end

  a_rdata_stable : assert property (@(posedge i_clk) disable iff (i_rst)
    (i_rdata != $past(i_rdata)) |-> $past(i_bus.cs && !i_bus.we))
    else begin
      fail_cnt++;
      $error("o_rdata changed without a bus read");
    end

endmodule

`default_nettype wire

// File: test/uart_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module uart_monitor (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  uart_pkg::bus_req_t          i_bus,
  input  logic [uart_pkg::DATA_W-1:0] i_rdata,
  input  logic                        i_tx
);

  localparam int BIT_CLKS = uart_pkg::OVERSAMPLE * uart_pkg::CLKS_PER_TICK;

  logic [15:0] model [0:4];     // Expected register contents.
  logic [15:0] last_rdata;
  logic [15:0] exp_rdata;
  logic        rd_pending;
  logic [7:0]  frame;
  logic [7:0]  frame_exp;
  logic        frame_stop;
  int          frames_seen;
  int          err_count;
  int          test_errs;
  int          tests_run;
  int          tests_failed;

  initial begin
    err_count    = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    frames_seen  = 0;
    rd_pending   = 1'b0;
  end

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    if (exp !== act) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic note_rx(input logic [7:0] b);
    model[3] = {8'h00, b};
    model[4] = 16'd1;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %s: %s (%0d errors)", name, (test_errs == 0) ? "PASS" : "FAIL", test_errs);
    test_errs = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus side of the model.
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 5; i++) model[i] = '0;
      last_rdata = '0;
      rd_pending = 1'b0;
    end else begin
      if (rd_pending) check_value("o_rdata", exp_rdata, i_rdata);
      rd_pending = 1'b0;
      if (i_bus.cs && !i_bus.we) begin
        if (i_bus.addr < 5) last_rdata = model[i_bus.addr];
        exp_rdata  = last_rdata;   // Out of range keeps the old value.
        rd_pending = 1'b1;
      end else if (i_bus.cs && i_bus.addr < 5) begin
        model[i_bus.addr] = i_bus.wdata;
      end
    end
  end

  // Serial frames on o_tx, sampled at bit centres.
  initial begin
    forever begin
      @(negedge i_tx);
      if (!i_rst) begin
        frame_exp = model[0][7:0];
        repeat (BIT_CLKS / 2) @(posedge i_clk);
        check_value("o_tx start bit", 16'd0, {15'd0, i_tx});
        for (int i = 0; i < 8; i++) begin
          repeat (BIT_CLKS) @(posedge i_clk);
          frame[i] = i_tx;
        end
        repeat (BIT_CLKS) @(posedge i_clk);
        frame_stop = i_tx;
        check_value("o_tx frame byte", {8'h00, frame_exp}, {8'h00, frame});
        check_value("o_tx stop bit", 16'd1, {15'd0, frame_stop});
        frames_seen++;
        model[1] = 16'd1;
        model[2] = 16'd0;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

  localparam int BIT_CLKS = uart_pkg::OVERSAMPLE * uart_pkg::CLKS_PER_TICK;
  localparam int LIMIT    = 2 * (20 * 10 * BIT_CLKS + 600);

  logic               i_clk;
  logic               i_rst;
  uart_pkg::bus_req_t i_bus;
  logic               i_rx;
  logic [15:0]        o_rdata;
  logic               o_tx;
  logic               o_cpu_enable;
  logic [31:0]        lfsr;
  int                 cycles;
  logic [7:0]         b;
  logic [10:0]        a;
  logic [15:0]        d;

  uart_top dut0 (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_bus        (i_bus),
    .o_rdata      (o_rdata),
    .i_rx         (i_rx),
    .o_tx         (o_tx),
    .o_cpu_enable (o_cpu_enable)
  );

  uart_monitor mon0 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_bus   (i_bus),
    .i_rdata (o_rdata),
    .i_tx    (o_tx)
  );

  bind uart_top uart_checker chk0 (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_bus        (i_bus),
    .i_rdata      (o_rdata),
    .i_tx         (o_tx),
    .i_cpu_enable (o_cpu_enable),
    .i_tx_done    (tx_done)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  // Galois LFSR, one step per bit taken.
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus and serial drivers. Each is entered just after a rising edge.
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_cycle(input logic we, input logic [10:0] addr, input logic [15:0] wd);
    uart_pkg::bus_req_t req;
    req.cs    = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.wdata = wd;
    i_bus <= req;
    @(posedge i_clk);
    i_bus <= '0;
    @(posedge i_clk);   // Read data is compared on this edge.
  endtask

  task automatic send_frame(input logic [7:0] v, input logic stop);
    i_rx <= 1'b0;
    repeat (BIT_CLKS) @(posedge i_clk);
    for (int i = 0; i < 8; i++) begin
      i_rx <= v[i];
      repeat (BIT_CLKS) @(posedge i_clk);
    end
    i_rx <= stop;
    repeat (BIT_CLKS) @(posedge i_clk);
    i_rx <= 1'b1;
    repeat (BIT_CLKS) @(posedge i_clk);
  endtask

  initial begin
    lfsr   = 32'hbe76_3bcd;
    cycles = 0;
    i_rst  = 1'b1;
    i_bus  = '0;
    i_rx   = 1'b1;
    repeat (2) @(posedge i_clk);
    i_rst <= 1'b0;
    @(posedge i_clk);

    for (int r = 0; r < 5; r++) bus_cycle(1'b0, 11'(r), '0);
    mon0.check_value("o_tx", 16'd1, {15'd0, o_tx});
    mon0.check_value("o_cpu_enable", 16'd0, {15'd0, o_cpu_enable});
    mon0.end_test("reset state");

    for (int r = 0; r < 5; r++) begin
      d = rand_bits(16);
      if (r == 2) d[0] = 1'b0;   // Bit 0 would start a frame.
      bus_cycle(1'b1, 11'(r), d);
      bus_cycle(1'b0, 11'(r), '0);
    end
    for (int k = 0; k < 8; k++) begin
      a = 11'(rand_bits(11));
      if (a < 5) a = a + 11'd5;
      bus_cycle(1'b1, a, rand_bits(16));
      bus_cycle(1'b0, a, '0);
    end
    for (int r = 0; r < 5; r++) bus_cycle(1'b0, 11'(r), '0);
    mon0.end_test("register read-back");

    for (int k = 0; k < 10; k++) begin
      b = 8'(rand_bits(8));
      send_frame(b, 1'b1);
      mon0.note_rx(b);
      bus_cycle(1'b0, 11'd3, '0);
      bus_cycle(1'b0, 11'd4, '0);
      bus_cycle(1'b1, 11'd4, '0);
    end
    mon0.end_test("receive");

    for (int k = 0; k < 10; k++) begin
      b = 8'(rand_bits(8));
      bus_cycle(1'b1, 11'd0, {8'h00, b});
      bus_cycle(1'b1, 11'd2, 16'd1);
      while (o_cpu_enable) @(posedge i_clk);
      repeat (2) @(posedge i_clk);
      mon0.check_value("tx frames", 16'(k + 1), 16'(mon0.frames_seen));
      bus_cycle(1'b0, 11'd1, '0);
      bus_cycle(1'b0, 11'd2, '0);
      bus_cycle(1'b1, 11'd1, '0);   // Each frame has to set TX_DONE again.
    end
    mon0.end_test("transmit");

    b = 8'(rand_bits(8));
    send_frame(b, 1'b0);
    bus_cycle(1'b0, 11'd4, '0);   // Model still holds the previous byte.
    bus_cycle(1'b0, 11'd3, '0);
    mon0.end_test("bad stop bit");

    $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             mon0.tests_run, mon0.tests_failed, mon0.err_count, dut0.chk0.fail_cnt);
    if (mon0.err_count == 0 && dut0.chk0.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hdl/uart_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_regs.sv
hdl/uart_top.sv
test/uart_checker.sv
test/uart_monitor.sv
test/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard hdl/*.sv test/*.sv)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
